// ==== verilog/issue_pkg.sv ====
`default_nettype none
// shared field widths and types for the issue stage
// load/store op codes and the memory-op classifier

package issue_pkg;

	// field widths of one instruction slot
	localparam int op_w  = 4;
	localparam int reg_w = 4;	// des, s1 and s2 share this width
	localparam int br_w  = 3;
	localparam int imm_w = 4;

	typedef logic [op_w-1:0]  op_t;	// operation code
	typedef logic [reg_w-1:0] reg_t;	// register index
	typedef logic [br_w-1:0]  br_t;	// branch tag, carried through untouched
	typedef logic [imm_w-1:0] imm_t;	// short immediate

	// memory ops, the only ones that need the memory port in lane 4
	localparam op_t op_load  = 4'd8;
	localparam op_t op_store = 4'd9;

	// true for any op that must leave the stage on the memory lane
	function automatic logic is_mem(op_t op);
		return (op == op_load) || (op == op_store);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/ins_swap.sv ====
`default_nettype none
// combinational lane exchange for a four-slot bundle
// flag pairs (lane k, lane 4) swap those two slots whole

module ins_swap
(
	input  wire                   ins1_swap,
	input  wire                   ins2_swap,
	input  wire                   ins3_swap,
	input  wire                   ins4_swap,

	input  wire                   in_1_vld, in_2_vld, in_3_vld, in_4_vld,
	input  wire issue_pkg::op_t   in_1_op, in_2_op, in_3_op, in_4_op,
	input  wire issue_pkg::reg_t  in_1_des, in_2_des, in_3_des, in_4_des,
	input  wire issue_pkg::reg_t  in_1_s1, in_2_s1, in_3_s1, in_4_s1,
	input  wire issue_pkg::reg_t  in_1_s2, in_2_s2, in_3_s2, in_4_s2,
	input  wire issue_pkg::br_t   in_1_branch, in_2_branch, in_3_branch, in_4_branch,
	input  wire issue_pkg::imm_t  in_1_ime, in_2_ime, in_3_ime, in_4_ime,

	output logic                  out_1_vld, out_2_vld, out_3_vld, out_4_vld,
	output issue_pkg::op_t        out_1_op, out_2_op, out_3_op, out_4_op,
	output issue_pkg::reg_t       out_1_des, out_2_des, out_3_des, out_4_des,
	output issue_pkg::reg_t       out_1_s1, out_2_s1, out_3_s1, out_4_s1,
	output issue_pkg::reg_t       out_1_s2, out_2_s2, out_3_s2, out_4_s2,
	output issue_pkg::br_t        out_1_branch, out_2_branch, out_3_branch, out_4_branch,
	output issue_pkg::imm_t       out_1_ime, out_2_ime, out_3_ime, out_4_ime
);

	// slots packed lane 4 .. lane 1, index 0 is lane 1
	logic [3:0]            i_vld;
	issue_pkg::op_t  [3:0] i_op;
	issue_pkg::reg_t [3:0] i_des;
	issue_pkg::reg_t [3:0] i_s1;
	issue_pkg::reg_t [3:0] i_s2;
	issue_pkg::br_t  [3:0] i_br;
	issue_pkg::imm_t [3:0] i_ime;
	logic [3:0][1:0]       src;	// source slot for each output slot

	assign i_vld = {in_4_vld, in_3_vld, in_2_vld, in_1_vld};
	assign i_op  = {in_4_op, in_3_op, in_2_op, in_1_op};
	assign i_des = {in_4_des, in_3_des, in_2_des, in_1_des};
	assign i_s1  = {in_4_s1, in_3_s1, in_2_s1, in_1_s1};
	assign i_s2  = {in_4_s2, in_3_s2, in_2_s2, in_1_s2};
	assign i_br  = {in_4_branch, in_3_branch, in_2_branch, in_1_branch};
	assign i_ime = {in_4_ime, in_3_ime, in_2_ime, in_1_ime};

	// only the three memory-lane patterns move anything
	always_comb
	begin
		case ({ins1_swap, ins2_swap, ins3_swap, ins4_swap})
			4'b1001: src = {2'd0, 2'd2, 2'd1, 2'd3};	// lane 1 <-> lane 4
			4'b0101: src = {2'd1, 2'd2, 2'd3, 2'd0};	// lane 2 <-> lane 4
			4'b0011: src = {2'd2, 2'd3, 2'd1, 2'd0};	// lane 3 <-> lane 4
			default: src = {2'd3, 2'd2, 2'd1, 2'd0};	// straight through
		endcase
	end

	assign {out_4_vld, out_3_vld, out_2_vld, out_1_vld} =
		{i_vld[src[3]], i_vld[src[2]], i_vld[src[1]], i_vld[src[0]]};
	assign {out_4_op, out_3_op, out_2_op, out_1_op} =
		{i_op[src[3]], i_op[src[2]], i_op[src[1]], i_op[src[0]]};
	assign {out_4_des, out_3_des, out_2_des, out_1_des} =
		{i_des[src[3]], i_des[src[2]], i_des[src[1]], i_des[src[0]]};
	assign {out_4_s1, out_3_s1, out_2_s1, out_1_s1} =
		{i_s1[src[3]], i_s1[src[2]], i_s1[src[1]], i_s1[src[0]]};
	assign {out_4_s2, out_3_s2, out_2_s2, out_1_s2} =
		{i_s2[src[3]], i_s2[src[2]], i_s2[src[1]], i_s2[src[0]]};
	// branch tag moves with its slot as well
	assign {out_4_branch, out_3_branch, out_2_branch, out_1_branch} =
		{i_br[src[3]], i_br[src[2]], i_br[src[1]], i_br[src[0]]};
	assign {out_4_ime, out_3_ime, out_2_ime, out_1_ime} =
		{i_ime[src[3]], i_ime[src[2]], i_ime[src[1]], i_ime[src[0]]};

endmodule

`default_nettype wire

// ==== verilog/mem_split.sv ====
`default_nettype none
// stage 1, bundle register plus pending mask
// releases one bundle as sub-bundles holding at most one memory op each

module mem_split #(
	parameter int lanes_in_bundle = 4
)
(
	input  wire                   clk,
	input  wire                   rst_n,

	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire                   in_1_vld, in_2_vld, in_3_vld, in_4_vld,
	input  wire issue_pkg::op_t   in_1_op, in_2_op, in_3_op, in_4_op,
	input  wire issue_pkg::reg_t  in_1_des, in_2_des, in_3_des, in_4_des,
	input  wire issue_pkg::reg_t  in_1_s1, in_2_s1, in_3_s1, in_4_s1,
	input  wire issue_pkg::reg_t  in_1_s2, in_2_s2, in_3_s2, in_4_s2,
	input  wire issue_pkg::br_t   in_1_branch, in_2_branch, in_3_branch, in_4_branch,
	input  wire issue_pkg::imm_t  in_1_ime, in_2_ime, in_3_ime, in_4_ime,

	output logic                  split_valid,
	input  wire                   split_ready,
	output logic                  split_1_vld, split_2_vld, split_3_vld, split_4_vld,
	output issue_pkg::op_t        split_1_op, split_2_op, split_3_op, split_4_op,
	output issue_pkg::reg_t       split_1_des, split_2_des, split_3_des, split_4_des,
	output issue_pkg::reg_t       split_1_s1, split_2_s1, split_3_s1, split_4_s1,
	output issue_pkg::reg_t       split_1_s2, split_2_s2, split_3_s2, split_4_s2,
	output issue_pkg::br_t        split_1_branch, split_2_branch, split_3_branch,
	output issue_pkg::br_t        split_4_branch,
	output issue_pkg::imm_t       split_1_ime, split_2_ime, split_3_ime, split_4_ime
);

	// held bundle, index 0 is lane 1
	issue_pkg::op_t  [lanes_in_bundle-1:0] b_op;
	issue_pkg::reg_t [lanes_in_bundle-1:0] b_des;
	issue_pkg::reg_t [lanes_in_bundle-1:0] b_s1;
	issue_pkg::reg_t [lanes_in_bundle-1:0] b_s2;
	issue_pkg::br_t  [lanes_in_bundle-1:0] b_br;
	issue_pkg::imm_t [lanes_in_bundle-1:0] b_ime;

	logic [lanes_in_bundle-1:0] pend;	// valid lanes not yet issued
	logic [lanes_in_bundle-1:0] mem_lane;	// pending lanes that hold a load/store
	logic [lanes_in_bundle-1:0] first_mem;	// lowest of those, one-hot
	logic [lanes_in_bundle-1:0] sel;	// lanes presented this cycle
	logic                       take;	// input handshake
	logic                       give;	// output handshake

	// new bundle only once the previous one is fully drained
	assign in_ready    = (pend == '0);
	assign split_valid = |pend;
	assign take        = in_valid && in_ready;
	assign give        = split_valid && split_ready;

	always_comb
	begin
		for (int i = 0; i < lanes_in_bundle; i++)
			mem_lane[i] = pend[i] && issue_pkg::is_mem(b_op[i]);

		// priority search, lowest lane wins
		first_mem = '0;
		for (int i = lanes_in_bundle - 1; i >= 0; i--)
			if (mem_lane[i])
			begin
				first_mem    = '0;
				first_mem[i] = 1'b1;
			end

		// all plain lanes go with the first memory op
		sel = (pend & ~mem_lane) | first_mem;
	end

	// an all-invalid bundle loads an empty mask and simply vanishes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pend <= '0;
		else if (take)
			pend <= {in_4_vld, in_3_vld, in_2_vld, in_1_vld};
		else if (give)
			pend <= pend & ~sel;	// retire what just left
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			b_op  <= {in_4_op, in_3_op, in_2_op, in_1_op};
			b_des <= {in_4_des, in_3_des, in_2_des, in_1_des};
			b_s1  <= {in_4_s1, in_3_s1, in_2_s1, in_1_s1};
			b_s2  <= {in_4_s2, in_3_s2, in_2_s2, in_1_s2};
			b_br  <= {in_4_branch, in_3_branch, in_2_branch, in_1_branch};
			b_ime <= {in_4_ime, in_3_ime, in_2_ime, in_1_ime};
		end
	end

	// lanes outside sel show vld low, fields as stored
	assign {split_4_vld, split_3_vld, split_2_vld, split_1_vld} = sel;
	assign {split_4_op, split_3_op, split_2_op, split_1_op}     = b_op;
	assign {split_4_des, split_3_des, split_2_des, split_1_des} = b_des;
	assign {split_4_s1, split_3_s1, split_2_s1, split_1_s1}     = b_s1;
	assign {split_4_s2, split_3_s2, split_2_s2, split_1_s2}     = b_s2;
	assign {split_4_branch, split_3_branch, split_2_branch, split_1_branch} = b_br;
	assign {split_4_ime, split_3_ime, split_2_ime, split_1_ime} = b_ime;

endmodule

`default_nettype wire

// ==== verilog/lane_route.sv ====
`default_nettype none
// stage 2, moves the memory op of a sub-bundle into lane 4
// swap flag decode plus the registered output bundle

module lane_route
(
	input  wire                   clk,
	input  wire                   rst_n,

	input  wire                   split_valid,
	output logic                  split_ready,
	input  wire                   split_1_vld, split_2_vld, split_3_vld, split_4_vld,
	input  wire issue_pkg::op_t   split_1_op, split_2_op, split_3_op, split_4_op,
	input  wire issue_pkg::reg_t  split_1_des, split_2_des, split_3_des, split_4_des,
	input  wire issue_pkg::reg_t  split_1_s1, split_2_s1, split_3_s1, split_4_s1,
	input  wire issue_pkg::reg_t  split_1_s2, split_2_s2, split_3_s2, split_4_s2,
	input  wire issue_pkg::br_t   split_1_branch, split_2_branch, split_3_branch,
	input  wire issue_pkg::br_t   split_4_branch,
	input  wire issue_pkg::imm_t  split_1_ime, split_2_ime, split_3_ime, split_4_ime,

	output logic                  out_valid,
	input  wire                   out_ready,
	output logic                  out_1_vld, out_2_vld, out_3_vld, out_4_vld,
	output issue_pkg::op_t        out_1_op, out_2_op, out_3_op, out_4_op,
	output issue_pkg::reg_t       out_1_des, out_2_des, out_3_des, out_4_des,
	output issue_pkg::reg_t       out_1_s1, out_2_s1, out_3_s1, out_4_s1,
	output issue_pkg::reg_t       out_1_s2, out_2_s2, out_3_s2, out_4_s2,
	output issue_pkg::br_t        out_1_branch, out_2_branch, out_3_branch, out_4_branch,
	output issue_pkg::imm_t       out_1_ime, out_2_ime, out_3_ime, out_4_ime
);

	logic mem_1, mem_2, mem_3;	// memory op sits in a non-memory lane
	logic load;	// split handshake, capture into output register

	// swapped sub-bundle ahead of the register
	logic            sw_1_vld, sw_2_vld, sw_3_vld, sw_4_vld;
	issue_pkg::op_t  sw_1_op, sw_2_op, sw_3_op, sw_4_op;
	issue_pkg::reg_t sw_1_des, sw_2_des, sw_3_des, sw_4_des;
	issue_pkg::reg_t sw_1_s1, sw_2_s1, sw_3_s1, sw_4_s1;
	issue_pkg::reg_t sw_1_s2, sw_2_s2, sw_3_s2, sw_4_s2;
	issue_pkg::br_t  sw_1_branch, sw_2_branch, sw_3_branch, sw_4_branch;
	issue_pkg::imm_t sw_1_ime, sw_2_ime, sw_3_ime, sw_4_ime;

	// stage 1 guarantees at most one of these is set
	assign mem_1 = split_1_vld && issue_pkg::is_mem(split_1_op);
	assign mem_2 = split_2_vld && issue_pkg::is_mem(split_2_op);
	assign mem_3 = split_3_vld && issue_pkg::is_mem(split_3_op);

	// lane 4 flag pairs with whichever lane holds the memory op
	ins_swap u_swap (
		.ins1_swap(mem_1), .ins2_swap(mem_2), .ins3_swap(mem_3),
		.ins4_swap(mem_1 | mem_2 | mem_3),
		.in_1_vld(split_1_vld), .in_1_op(split_1_op), .in_1_des(split_1_des),
		.in_1_s1(split_1_s1), .in_1_s2(split_1_s2), .in_1_branch(split_1_branch),
		.in_1_ime(split_1_ime),
		.in_2_vld(split_2_vld), .in_2_op(split_2_op), .in_2_des(split_2_des),
		.in_2_s1(split_2_s1), .in_2_s2(split_2_s2), .in_2_branch(split_2_branch),
		.in_2_ime(split_2_ime),
		.in_3_vld(split_3_vld), .in_3_op(split_3_op), .in_3_des(split_3_des),
		.in_3_s1(split_3_s1), .in_3_s2(split_3_s2), .in_3_branch(split_3_branch),
		.in_3_ime(split_3_ime),
		.in_4_vld(split_4_vld), .in_4_op(split_4_op), .in_4_des(split_4_des),
		.in_4_s1(split_4_s1), .in_4_s2(split_4_s2), .in_4_branch(split_4_branch),
		.in_4_ime(split_4_ime),
		.out_1_vld(sw_1_vld), .out_1_op(sw_1_op), .out_1_des(sw_1_des),
		.out_1_s1(sw_1_s1), .out_1_s2(sw_1_s2), .out_1_branch(sw_1_branch),
		.out_1_ime(sw_1_ime),
		.out_2_vld(sw_2_vld), .out_2_op(sw_2_op), .out_2_des(sw_2_des),
		.out_2_s1(sw_2_s1), .out_2_s2(sw_2_s2), .out_2_branch(sw_2_branch),
		.out_2_ime(sw_2_ime),
		.out_3_vld(sw_3_vld), .out_3_op(sw_3_op), .out_3_des(sw_3_des),
		.out_3_s1(sw_3_s1), .out_3_s2(sw_3_s2), .out_3_branch(sw_3_branch),
		.out_3_ime(sw_3_ime),
		.out_4_vld(sw_4_vld), .out_4_op(sw_4_op), .out_4_des(sw_4_des),
		.out_4_s1(sw_4_s1), .out_4_s2(sw_4_s2), .out_4_branch(sw_4_branch),
		.out_4_ime(sw_4_ime)
	);

	// accept while empty or while the current entry drains this edge
	assign split_ready = !out_valid || out_ready;
	assign load        = split_valid && split_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;	// drained, nothing behind it
	end

	// payload only moves on a capture, so it holds under stall
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			{out_4_vld, out_3_vld, out_2_vld, out_1_vld} <=
				{sw_4_vld, sw_3_vld, sw_2_vld, sw_1_vld};
			{out_4_op, out_3_op, out_2_op, out_1_op} <= {sw_4_op, sw_3_op, sw_2_op, sw_1_op};
			{out_4_des, out_3_des, out_2_des, out_1_des} <=
				{sw_4_des, sw_3_des, sw_2_des, sw_1_des};
			{out_4_s1, out_3_s1, out_2_s1, out_1_s1} <= {sw_4_s1, sw_3_s1, sw_2_s1, sw_1_s1};
			{out_4_s2, out_3_s2, out_2_s2, out_1_s2} <= {sw_4_s2, sw_3_s2, sw_2_s2, sw_1_s2};
			{out_4_branch, out_3_branch, out_2_branch, out_1_branch} <=
				{sw_4_branch, sw_3_branch, sw_2_branch, sw_1_branch};
			{out_4_ime, out_3_ime, out_2_ime, out_1_ime} <=
				{sw_4_ime, sw_3_ime, sw_2_ime, sw_1_ime};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/issue_top.sv ====
`default_nettype none
// issue stage top, memory split followed by lane routing
// bundles in, sub-bundles out with any load/store in lane 4

module issue_top #(
	parameter int lanes_in_bundle = 4
)
(
	input  wire                   clk,
	input  wire                   rst_n,

	input  wire                   in_valid,
	output logic                  in_ready,
	input  wire                   in_1_vld, in_2_vld, in_3_vld, in_4_vld,
	input  wire issue_pkg::op_t   in_1_op, in_2_op, in_3_op, in_4_op,
	input  wire issue_pkg::reg_t  in_1_des, in_2_des, in_3_des, in_4_des,
	input  wire issue_pkg::reg_t  in_1_s1, in_2_s1, in_3_s1, in_4_s1,
	input  wire issue_pkg::reg_t  in_1_s2, in_2_s2, in_3_s2, in_4_s2,
	input  wire issue_pkg::br_t   in_1_branch, in_2_branch, in_3_branch, in_4_branch,
	input  wire issue_pkg::imm_t  in_1_ime, in_2_ime, in_3_ime, in_4_ime,

	output logic                  out_valid,
	input  wire                   out_ready,
	output logic                  out_1_vld, out_2_vld, out_3_vld, out_4_vld,
	output issue_pkg::op_t        out_1_op, out_2_op, out_3_op, out_4_op,
	output issue_pkg::reg_t       out_1_des, out_2_des, out_3_des, out_4_des,
	output issue_pkg::reg_t       out_1_s1, out_2_s1, out_3_s1, out_4_s1,
	output issue_pkg::reg_t       out_1_s2, out_2_s2, out_3_s2, out_4_s2,
	output issue_pkg::br_t        out_1_branch, out_2_branch, out_3_branch, out_4_branch,
	output issue_pkg::imm_t       out_1_ime, out_2_ime, out_3_ime, out_4_ime
);

	// handshake and lanes between the two stages
	logic            split_valid;
	logic            split_ready;
	logic            split_1_vld, split_2_vld, split_3_vld, split_4_vld;
	issue_pkg::op_t  split_1_op, split_2_op, split_3_op, split_4_op;
	issue_pkg::reg_t split_1_des, split_2_des, split_3_des, split_4_des;
	issue_pkg::reg_t split_1_s1, split_2_s1, split_3_s1, split_4_s1;
	issue_pkg::reg_t split_1_s2, split_2_s2, split_3_s2, split_4_s2;
	issue_pkg::br_t  split_1_branch, split_2_branch, split_3_branch, split_4_branch;
	issue_pkg::imm_t split_1_ime, split_2_ime, split_3_ime, split_4_ime;

	// port names line up with the local nets, so implicit connection is enough
	mem_split #(
		.lanes_in_bundle(lanes_in_bundle)
	) u_split (.*);	// one memory op per sub-bundle

	lane_route u_route (.*);	// memory op to lane 4, one register stage

endmodule

`default_nettype wire

// ==== sim/issue_asserts.sv ====
`default_nettype none
// bound checks for issue_top on the split and output side
// memory lane placement, one memory op per sub-bundle, stall stability, idle during reset

module issue_asserts
(
	input wire                  clk,
	input wire                  rst_n,
	input wire                  split_valid,
	input wire                  split_1_vld, split_2_vld, split_3_vld, split_4_vld,
	input wire issue_pkg::op_t  split_1_op, split_2_op, split_3_op, split_4_op,
	input wire                  out_valid,
	input wire                  out_ready,
	input wire                  out_1_vld, out_2_vld, out_3_vld, out_4_vld,
	input wire issue_pkg::op_t  out_1_op, out_2_op, out_3_op, out_4_op,
	input wire issue_pkg::reg_t out_1_des, out_2_des, out_3_des, out_4_des,
	input wire issue_pkg::reg_t out_1_s1, out_2_s1, out_3_s1, out_4_s1,
	input wire issue_pkg::reg_t out_1_s2, out_2_s2, out_3_s2, out_4_s2,
	input wire issue_pkg::br_t  out_1_branch, out_2_branch, out_3_branch, out_4_branch,
	input wire issue_pkg::imm_t out_1_ime, out_2_ime, out_3_ime, out_4_ime
);

	logic [3:0]  split_mem;	// valid load/store per lane of the sub-bundle
	logic [3:0]  mem;	// valid load/store per lane
	logic [95:0] word;	// whole presented bundle

	assign split_mem = {split_4_vld && issue_pkg::is_mem(split_4_op),
		split_3_vld && issue_pkg::is_mem(split_3_op),
		split_2_vld && issue_pkg::is_mem(split_2_op),
		split_1_vld && issue_pkg::is_mem(split_1_op)};
	assign mem = {out_4_vld && issue_pkg::is_mem(out_4_op),
		out_3_vld && issue_pkg::is_mem(out_3_op),
		out_2_vld && issue_pkg::is_mem(out_2_op),
		out_1_vld && issue_pkg::is_mem(out_1_op)};
	assign word = {out_4_vld, out_4_op, out_4_des, out_4_s1, out_4_s2, out_4_branch, out_4_ime,
		out_3_vld, out_3_op, out_3_des, out_3_s1, out_3_s2, out_3_branch, out_3_ime,
		out_2_vld, out_2_op, out_2_des, out_2_s1, out_2_s2, out_2_branch, out_2_ime,
		out_1_vld, out_1_op, out_1_des, out_1_s1, out_1_s2, out_1_branch, out_1_ime};

	mem_in_lane4: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> mem[2:0] == 3'b000)
		else $error("memory op left the stage outside lane 4");

	// stage 1 output, before the swap can hide a second memory op
	one_mem: assert property (@(posedge clk) disable iff (!rst_n)
		split_valid |-> $countones(split_mem) <= 1)
		else $error("more than one memory op in one sub-bundle");

	// held sub-bundle must not change until it is taken
	stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(word))
		else $error("output changed while stalled");

	reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind issue_top issue_asserts u_asserts (.*);

`default_nettype wire

// ==== sim/issue_tb.sv ====
`default_nettype none
// issue stage testbench with a stimulus table, a sub-bundle model and random out_ready
// each output transfer is compared against the expected queue

module issue_tb;

	localparam int n_tests  = 12;
	localparam int time_out = 200;	// edges allowed for any one wait

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic            in_ready;
	logic            out_valid;
	logic            out_ready;
	logic            in_1_vld, in_2_vld, in_3_vld, in_4_vld;
	issue_pkg::op_t  in_1_op, in_2_op, in_3_op, in_4_op;
	issue_pkg::reg_t in_1_des, in_2_des, in_3_des, in_4_des;
	issue_pkg::reg_t in_1_s1, in_2_s1, in_3_s1, in_4_s1;
	issue_pkg::reg_t in_1_s2, in_2_s2, in_3_s2, in_4_s2;
	issue_pkg::br_t  in_1_branch, in_2_branch, in_3_branch, in_4_branch;
	issue_pkg::imm_t in_1_ime, in_2_ime, in_3_ime, in_4_ime;
	logic            out_1_vld, out_2_vld, out_3_vld, out_4_vld;
	issue_pkg::op_t  out_1_op, out_2_op, out_3_op, out_4_op;
	issue_pkg::reg_t out_1_des, out_2_des, out_3_des, out_4_des;
	issue_pkg::reg_t out_1_s1, out_2_s1, out_3_s1, out_4_s1;
	issue_pkg::reg_t out_1_s2, out_2_s2, out_3_s2, out_4_s2;
	issue_pkg::br_t  out_1_branch, out_2_branch, out_3_branch, out_4_branch;
	issue_pkg::imm_t out_1_ime, out_2_ime, out_3_ime, out_4_ime;

	// lane word is {vld, op, des, s1, s2, branch, ime}, lane 1 in the low 24 bits
	logic [95:0] in_word;
	logic [95:0] act;

	// op nibbles lane 4 .. lane 1, 8 is a load and 9 a store
	string       t_name [n_tests] = '{"no_mem", "mem_lane1", "mem_lane2", "mem_lane3",
		"mem_lane4", "two_mem", "three_mem", "four_mem", "invalid_mem", "all_invalid",
		"partial_two", "one_lane"};
	logic [15:0] t_op  [n_tests] = '{16'h4321, 16'h3218, 16'h3291, 16'h5811, 16'h9321,
		16'h3829, 16'h8981, 16'h9889, 16'h2183, 16'h9898, 16'h8a89, 16'h0800};
	logic [3:0]  t_vld [n_tests] = '{4'hf, 4'hf, 4'hf, 4'hf, 4'hf, 4'hf, 4'hf, 4'hf,
		4'b1101, 4'b0000, 4'b1011, 4'b0100};

	logic [95:0] exp_q[$];	// expected sub-bundles in output order
	bit          first_q[$];	// marks the first sub-bundle of a bundle
	logic [95:0] exp_w;
	bit          is_first;
	string       cur_name;
	string       phase_name;
	bit          hold_ready;	// out_ready pinned high, latency is checked
	bit          aborted;
	int          cyc = 0;
	int          acc_cyc;	// edge count at input acceptance
	int          got_cnt;
	int          exp_cnt;
	int          test_err;
	int          err_total;
	int          tests_run;
	int          tests_failed;

	issue_top #(
		.lanes_in_bundle(4)
	) dut0 (.*);

	assign {in_4_vld, in_4_op, in_4_des, in_4_s1, in_4_s2, in_4_branch, in_4_ime,
		in_3_vld, in_3_op, in_3_des, in_3_s1, in_3_s2, in_3_branch, in_3_ime,
		in_2_vld, in_2_op, in_2_des, in_2_s1, in_2_s2, in_2_branch, in_2_ime,
		in_1_vld, in_1_op, in_1_des, in_1_s1, in_1_s2, in_1_branch, in_1_ime} = in_word;
	assign act = {out_4_vld, out_4_op, out_4_des, out_4_s1, out_4_s2, out_4_branch, out_4_ime,
		out_3_vld, out_3_op, out_3_des, out_3_s1, out_3_s2, out_3_branch, out_3_ime,
		out_2_vld, out_2_op, out_2_des, out_2_s1, out_2_s2, out_2_branch, out_2_ime,
		out_1_vld, out_1_op, out_1_des, out_1_s1, out_1_s2, out_1_branch, out_1_ime};

	always #4 clk = ~clk;

	// fields other than op come from entry and lane, so no two lanes match
	function automatic logic [23:0] stim_lane(int idx, int l, logic v);
		issue_pkg::op_t op;
		op = t_op[idx][4*l +: 4];
		return {v, op, 4'(idx), 4'(l + 4), 4'(idx + 3 * l), 3'(idx + l), 4'(idx * 2 + l)};
	endfunction

	task automatic note_error();
		test_err++;
		err_total++;
	endtask

	// split into sub-bundles, then move each memory op to lane 4
	task automatic model_bundle(input logic [95:0] bundle);
		logic [3:0]  pend;
		logic [3:0]  mem;
		logic [3:0]  sel;
		logic [23:0] ln [4];
		logic [23:0] tmp;
		int          first;
		int          cnt;
		cnt = 0;
		for (int l = 0; l < 4; l++)
			pend[l] = bundle[24*l + 23];
		while (pend != 4'b0000)
		begin
			first = -1;
			for (int l = 3; l >= 0; l--)
			begin
				mem[l] = pend[l] && issue_pkg::is_mem(bundle[24*l + 22 -: 4]);
				if (mem[l])
					first = l;	// ends on the lowest memory lane
			end
			sel = pend & ~mem;
			if (first >= 0)
				sel[first] = 1'b1;
			for (int l = 0; l < 4; l++)
			begin
				ln[l]     = bundle[24*l +: 24];
				ln[l][23] = sel[l];	// unsent lanes keep their fields, vld low
			end
			if (first >= 0 && first < 3)
			begin
				tmp       = ln[first];
				ln[first] = ln[3];
				ln[3]     = tmp;
			end
			exp_q.push_back({ln[3], ln[2], ln[1], ln[0]});
			first_q.push_back(cnt == 0);
			cnt++;
			pend = pend & ~sel;
		end
		exp_cnt = cnt;
	endtask

	task automatic run_test(input int idx);
		logic [95:0] bundle;
		logic        accepted;
		int          n;
		bundle = {stim_lane(idx, 3, t_vld[idx][3]), stim_lane(idx, 2, t_vld[idx][2]),
			stim_lane(idx, 1, t_vld[idx][1]), stim_lane(idx, 0, t_vld[idx][0])};
		test_err = 0;
		got_cnt  = 0;
		cur_name = t_name[idx];
		model_bundle(bundle);
		in_word  <= bundle;
		in_valid <= 1'b1;
		n        = 0;
		accepted = 1'b0;
		while (!accepted && n < time_out)
		begin
			@(posedge clk);
			n++;
			accepted = in_ready;	// in_valid is high at this edge
		end
		in_valid <= 1'b0;
		acc_cyc  = cyc;
		if (!accepted)
		begin
			$display("no input handshake within %0d cycles in test %s", time_out, cur_name);
			aborted = 1'b1;
		end
		else
		begin
			// nothing is pending between tests, so the bundle goes in at once
			if (n != 1)
			begin
				$display("Error %s accept edge expected 1 actual %0d", cur_name, n);
				note_error();
			end
			// mask now holds the valid lanes, empty only for an all-invalid bundle
			@(posedge clk);
			if (in_ready !== (t_vld[idx] == 4'b0000))
			begin
				$display("Error %s in_ready expected %0b actual %0b", cur_name,
					t_vld[idx] == 4'b0000, in_ready);
				note_error();
			end
			// two edges is the earliest any output of this bundle can show up
			n = 1;
			while ((exp_q.size() != 0 || cyc - acc_cyc < 2 || out_valid) && n < time_out)
			begin
				@(posedge clk);
				n++;
			end
			if (exp_q.size() != 0 || out_valid)
			begin
				$display("test %s still had %0d sub-bundles missing after %0d cycles",
					cur_name, exp_q.size(), time_out);
				aborted = 1'b1;
			end
			else if (got_cnt != exp_cnt)
			begin
				$display("Error %s sub-bundle count expected %0d actual %0d", cur_name,
					exp_cnt, got_cnt);
				note_error();
			end
		end
		tests_run++;
		if (test_err != 0 || aborted)
			tests_failed++;
		$display("%s %s %0d sub-bundles, %0d errors", phase_name, cur_name, got_cnt, test_err);
	endtask

	// output monitor, values read here are the ones that transfer at this edge
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (rst_n && out_valid && out_ready)
		begin
			got_cnt++;
			if (exp_q.size() == 0)
			begin
				$display("the DUT sent a sub-bundle nobody expected in test %s", cur_name);
				note_error();
			end
			else
			begin
				exp_w    = exp_q.pop_front();
				is_first = first_q.pop_front();
				if (act !== exp_w)
				begin
					$display("Error %s sub-bundle %0d expected %h actual %h", cur_name, got_cnt,
						exp_w, act);
					note_error();
				end
				if (is_first && hold_ready && cyc - acc_cyc != 2)
				begin
					$display("Error %s latency expected 2 actual %0d", cur_name, cyc - acc_cyc);
					note_error();
				end
			end
		end
	end

	always @(posedge clk)
	begin
		if (hold_ready)
			out_ready <= 1'b1;
		else
			out_ready <= 1'($urandom_range(1, 0));	// random stall
	end

	initial
	begin
		void'($urandom(19267));
		clk          = 1'b0;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_word      = '0;
		out_ready    = 1'b1;
		hold_ready   = 1'b1;
		aborted      = 1'b0;
		err_total    = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// pass 0 with out_ready high, pass 1 under random back-pressure
		for (int p = 0; p < 2; p++)
		begin
			hold_ready <= (p == 0);
			phase_name = (p == 0) ? "ready_high" : "backpressure";
			for (int i = 0; i < n_tests; i++)
				if (!aborted)
					run_test(i);
		end
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
		if (aborted || err_total != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/issue_pkg.sv
verilog/ins_swap.sv
verilog/mem_split.sv
verilog/lane_route.sv
verilog/issue_top.sv
sim/issue_asserts.sv
sim/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the issue stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module issue_tb \
	-Mdir obj_dir -o issue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/issue_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
